// File: flist.f
src/wb_pkg.sv
src/iob_wb_bridge.sv
src/wb_arbiter.sv
src/wb_ram.sv
src/wb_subsystem.sv
sim/wb_arbiter_checker.sv
sim/tb_wb_subsystem.sv

// File: Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module tb_wb_subsystem \
		-Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation stopped early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_wb_subsystem.sv
`default_nettype none

module tb_wb_subsystem;

   timeunit 1ns;
   timeprecision 100ps;

   import wb_pkg::*;

   logic              clk_i;
   logic              cke_i;
   logic              rst_n_i;
   logic              a_iob_avalid_i;
   logic [ADDR_W-1:0] a_iob_addr_i;
   logic [DATA_W-1:0] a_iob_wdata_i;
   logic [STRB_W-1:0] a_iob_wstrb_i;
   logic              a_iob_ready_o;
   logic              a_iob_rvalid_o;
   logic [DATA_W-1:0] a_iob_rdata_o;
   logic              b_iob_avalid_i;
   logic [ADDR_W-1:0] b_iob_addr_i;
   logic [DATA_W-1:0] b_iob_wdata_i;
   logic [STRB_W-1:0] b_iob_wstrb_i;
   logic              b_iob_ready_o;
   logic              b_iob_rvalid_o;
   logic [DATA_W-1:0] b_iob_rdata_o;

   // stimulus table, one entry per row in each queue
   logic [1:0]        row_ports[$];  // bit 0 port a, bit 1 port b
   logic [ADDR_W-1:0] row_a_addr[$];
   logic [DATA_W-1:0] row_a_data[$];
   logic [STRB_W-1:0] row_a_strb[$];
   logic [ADDR_W-1:0] row_b_addr[$];
   logic [DATA_W-1:0] row_b_data[$];
   logic [STRB_W-1:0] row_b_strb[$];
   int                row_stall[$];  // cycles of cke low after capture
   logic [DATA_W-1:0] row_a_exp[$];
   logic [DATA_W-1:0] row_b_exp[$];
   int                row_a_lat[$];
   int                row_b_lat[$];

   logic [DATA_W-1:0] model_mem[MEM_WORDS];
   logic              b_served_last = 1'b1;  // reset priority favours a
   int                cycle_cnt = 0;
   int                cycle_limit = 50;

   wb_subsystem wb_subsystem_i (
      .clk_i          (clk_i),
      .cke_i          (cke_i),
      .rst_n_i        (rst_n_i),
      .a_iob_avalid_i (a_iob_avalid_i),
      .a_iob_addr_i   (a_iob_addr_i),
      .a_iob_wdata_i  (a_iob_wdata_i),
      .a_iob_wstrb_i  (a_iob_wstrb_i),
      .a_iob_ready_o  (a_iob_ready_o),
      .a_iob_rvalid_o (a_iob_rvalid_o),
      .a_iob_rdata_o  (a_iob_rdata_o),
      .b_iob_avalid_i (b_iob_avalid_i),
      .b_iob_addr_i   (b_iob_addr_i),
      .b_iob_wdata_i  (b_iob_wdata_i),
      .b_iob_wstrb_i  (b_iob_wstrb_i),
      .b_iob_ready_o  (b_iob_ready_o),
      .b_iob_rvalid_o (b_iob_rvalid_o),
      .b_iob_rdata_o  (b_iob_rdata_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout: the table did not finish within %0d cycles", cycle_limit);
         $display("Done: errors found");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
      if (got !== exp) begin
         $display("error at %0d ns: %s, got %h expected %h", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // byte-strobe write into the model, returns the word after it
   function automatic logic [DATA_W-1:0] update_model(logic [ADDR_W-1:0] addr,
                                                      logic [DATA_W-1:0] data,
                                                      logic [STRB_W-1:0] strb);
      logic [MEM_AW-1:0] idx;
      idx = addr[MEM_AW+1:2];  // upper bits alias
      for (int i = 0; i < STRB_W; i++) begin
         if (strb[i]) begin
            model_mem[idx][8*i+:8] = data[8*i+:8];
         end
      end
      return model_mem[idx];
   endfunction

   task automatic add_row(input logic [1:0] ports,
                          input logic [ADDR_W-1:0] a_addr, input logic [STRB_W-1:0] a_strb,
                          input logic [ADDR_W-1:0] b_addr, input logic [STRB_W-1:0] b_strb,
                          input int stall);
      logic [DATA_W-1:0] a_data;
      logic [DATA_W-1:0] b_data;
      logic [DATA_W-1:0] a_word;
      logic [DATA_W-1:0] b_word;
      int                a_lat;
      int                b_lat;
      a_data = $urandom();
      b_data = $urandom();
      a_word = '0;
      b_word = '0;
      a_lat = 0;
      b_lat = 0;
      if (ports == 2'b01) begin
         a_word = update_model(a_addr, a_data, a_strb);
         a_lat = 3 + stall;
         b_served_last = 1'b0;
      end else if (ports == 2'b10) begin
         b_word = update_model(b_addr, b_data, b_strb);
         b_lat = 3 + stall;
         b_served_last = 1'b1;
      end else if (b_served_last) begin
         a_word = update_model(a_addr, a_data, a_strb);  // a wins the tie
         b_word = update_model(b_addr, b_data, b_strb);
         a_lat = 3;
         b_lat = 5;
      end else begin
         b_word = update_model(b_addr, b_data, b_strb);
         a_word = update_model(a_addr, a_data, a_strb);
         b_lat = 3;
         a_lat = 5;
      end
      row_ports.push_back(ports);
      row_a_addr.push_back(a_addr);
      row_a_data.push_back(a_data);
      row_a_strb.push_back(a_strb);
      row_b_addr.push_back(b_addr);
      row_b_data.push_back(b_data);
      row_b_strb.push_back(b_strb);
      row_stall.push_back(stall);
      row_a_exp.push_back(a_word);
      row_b_exp.push_back(b_word);
      row_a_lat.push_back(a_lat);
      row_b_lat.push_back(b_lat);
   endtask

   task automatic build_table();
      add_row(2'b01, 32'h10, 4'hf, 32'h0, 4'h0, 0);  // full word write, read back
      add_row(2'b01, 32'h10, 4'h0, 32'h0, 4'h0, 0);
      add_row(2'b01, 32'h20, 4'hf, 32'h0, 4'h0, 0);
      add_row(2'b01, 32'h20, 4'b0101, 32'h0, 4'h0, 0);  // partial strobes
      add_row(2'b10, 32'h0, 4'h0, 32'h20, 4'b1000, 0);
      add_row(2'b01, 32'h20, 4'h0, 32'h0, 4'h0, 0);
      add_row(2'b10, 32'h0, 4'h0, 32'h20, 4'h0, 0);
      add_row(2'b11, 32'h40, 4'hf, 32'h80, 4'hf, 0);  // both ports, different words
      add_row(2'b11, 32'h80, 4'h0, 32'h40, 4'h0, 0);
      add_row(2'b11, 32'h44, 4'hf, 32'h40, 4'h0, 0);
      add_row(2'b11, 32'h100, 4'hf, 32'h100, 4'h3, 0);  // same word, a first
      add_row(2'b10, 32'h0, 4'h0, 32'h100, 4'h0, 0);
      add_row(2'b01, 32'h104, 4'hf, 32'h0, 4'h0, 0);
      add_row(2'b11, 32'h104, 4'h3, 32'h104, 4'hf, 0);  // now b first
      add_row(2'b01, 32'h104, 4'h0, 32'h0, 4'h0, 0);
      add_row(2'b01, 32'h10, 4'h0, 32'h0, 4'h0, 4);  // cke stalls
      add_row(2'b10, 32'h0, 4'h0, 32'h80, 4'h0, 2);
      add_row(2'b01, 32'h20, 4'b0110, 32'h0, 4'h0, 3);
      add_row(2'b01, 32'hc10, 4'hf, 32'h0, 4'h0, 0);  // aliases onto word 0x10
      add_row(2'b01, 32'h10, 4'h0, 32'h0, 4'h0, 0);
      add_row(2'b10, 32'h0, 4'h0, 32'h440, 4'h0, 0);
      add_row(2'b11, 32'h1000_0020, 4'h0, 32'hffff_fc80, 4'h0, 0);
   endtask

   task automatic run_row(input int r);
      logic [1:0]        ports;
      logic              done_a;
      logic              done_b;
      int                k;
      int                lat_a;
      int                lat_b;
      int                rv_a;
      int                rv_b;
      logic [DATA_W-1:0] got_a;
      logic [DATA_W-1:0] got_b;
      ports = row_ports[r];
      if (ports[0]) compare_values(int'(a_iob_ready_o), 1, "port a ready before request");
      if (ports[1]) compare_values(int'(b_iob_ready_o), 1, "port b ready before request");
      @(posedge clk_i);
      a_iob_avalid_i <= ports[0];
      a_iob_addr_i   <= row_a_addr[r];
      a_iob_wdata_i  <= row_a_data[r];
      a_iob_wstrb_i  <= row_a_strb[r];
      b_iob_avalid_i <= ports[1];
      b_iob_addr_i   <= row_b_addr[r];
      b_iob_wdata_i  <= row_b_data[r];
      b_iob_wstrb_i  <= row_b_strb[r];
      done_a = ~ports[0];
      done_b = ~ports[1];
      k = 0;
      lat_a = 0;
      lat_b = 0;
      rv_a = 0;
      rv_b = 0;
      got_a = '0;
      got_b = '0;
      while (!(done_a && done_b)) begin
         @(posedge clk_i);
         k++;
         if (k == 1) begin
            a_iob_avalid_i <= 1'b0;
            b_iob_avalid_i <= 1'b0;
            if (row_stall[r] > 0) cke_i <= 1'b0;  // freeze mid-transfer
         end else if (k == row_stall[r] + 1) begin
            cke_i <= 1'b1;
         end
         @(negedge clk_i);
         if (a_iob_rvalid_o) begin
            rv_a++;
            got_a = a_iob_rdata_o;
         end
         if (b_iob_rvalid_o) begin
            rv_b++;
            got_b = b_iob_rdata_o;
         end
         if (!done_a && a_iob_ready_o) begin
            done_a = 1'b1;
            lat_a = k;
         end
         if (!done_b && b_iob_ready_o) begin
            done_b = 1'b1;
            lat_b = k;
         end
      end
      compare_values(rv_a, (ports[0] && row_a_strb[r] == 4'd0) ? 1 : 0, "port a rvalid pulses");
      compare_values(rv_b, (ports[1] && row_b_strb[r] == 4'd0) ? 1 : 0, "port b rvalid pulses");
      if (ports[0]) begin
         compare_values(lat_a, row_a_lat[r], "port a cycles from avalid to ready");
         if (row_a_strb[r] == 4'd0) compare_values(got_a, row_a_exp[r], "port a read data");
      end
      if (ports[1]) begin
         compare_values(lat_b, row_b_lat[r], "port b cycles from avalid to ready");
         if (row_b_strb[r] == 4'd0) compare_values(got_b, row_b_exp[r], "port b read data");
      end
   endtask

   initial begin
      void'($urandom(32'h423c));
      cke_i = 1'b1;
      rst_n_i = 1'b0;
      a_iob_avalid_i = 1'b0;
      a_iob_addr_i = '0;
      a_iob_wdata_i = '0;
      a_iob_wstrb_i = '0;
      b_iob_avalid_i = 1'b0;
      b_iob_addr_i = '0;
      b_iob_wdata_i = '0;
      b_iob_wstrb_i = '0;
      build_table();
      cycle_limit = row_ports.size() * 12 + 50;
      repeat (3) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      for (int r = 0; r < row_ports.size(); r++) begin
         run_row(r);
      end
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/wb_arbiter_checker.sv
`default_nettype none

module wb_arbiter_checker (
   input logic                      clk_i,
   input logic                      rst_n_i,
   input logic                      s_cyc_i,
   input logic                      s_stb_i,
   input logic [wb_pkg::ADDR_W-1:0] s_addr_i,
   input logic                      s_ack_i,
   input logic                      m0_cyc_i,
   input logic                      m1_cyc_i,
   input logic                      m0_ack_i,
   input logic                      m1_ack_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // a waiting strobe keeps its address
   addr_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      s_stb_i && !s_ack_i |=> !s_stb_i || $stable(s_addr_i))
      else $error("slave address changed while stb waited for ack");

   stb_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      s_stb_i |-> s_cyc_i)
      else $error("slave stb high without cyc");

   // ack reaches exactly one master, and that master has its cycle open
   one_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      s_ack_i |-> (m0_ack_i && m0_cyc_i && !m1_ack_i) ||
                  (m1_ack_i && m1_cyc_i && !m0_ack_i))
      else $error("ack not delivered to exactly one master with an open cycle");

   ack_after_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      s_ack_i |-> $past(s_stb_i))
      else $error("ack without a strobe in the cycle before");

endmodule

bind wb_arbiter wb_arbiter_checker arbiter_checker (
   .clk_i    (clk_i),
   .rst_n_i  (rst_n_i),
   .s_cyc_i  (s_cyc_o),
   .s_stb_i  (s_stb_o),
   .s_addr_i (s_addr_o),
   .s_ack_i  (s_ack_i),
   .m0_cyc_i (m0_cyc_i),
   .m1_cyc_i (m1_cyc_i),
   .m0_ack_i (m0_ack_o),
   .m1_ack_i (m1_ack_o)
);

`default_nettype wire

// File: src/wb_subsystem.sv
`default_nettype none

module wb_subsystem (
   input  logic                      clk_i,
   input  logic                      cke_i,
   input  logic                      rst_n_i,

   // port a
   input  logic                      a_iob_avalid_i,
   input  logic [wb_pkg::ADDR_W-1:0] a_iob_addr_i,
   input  logic [wb_pkg::DATA_W-1:0] a_iob_wdata_i,
   input  logic [wb_pkg::STRB_W-1:0] a_iob_wstrb_i,
   output logic                      a_iob_ready_o,
   output logic                      a_iob_rvalid_o,
   output logic [wb_pkg::DATA_W-1:0] a_iob_rdata_o,

   // port b
   input  logic                      b_iob_avalid_i,
   input  logic [wb_pkg::ADDR_W-1:0] b_iob_addr_i,
   input  logic [wb_pkg::DATA_W-1:0] b_iob_wdata_i,
   input  logic [wb_pkg::STRB_W-1:0] b_iob_wstrb_i,
   output logic                      b_iob_ready_o,
   output logic                      b_iob_rvalid_o,
   output logic [wb_pkg::DATA_W-1:0] b_iob_rdata_o
);

   import wb_pkg::*;

   // bridge a to arbiter
   logic              wba_cyc;
   logic              wba_stb;
   logic              wba_we;
   logic [ADDR_W-1:0] wba_addr;
   logic [STRB_W-1:0] wba_sel;
   logic [DATA_W-1:0] wba_wdata;
   logic              wba_ack;
   logic [DATA_W-1:0] wba_rdata;

   // bridge b to arbiter
   logic              wbb_cyc;
   logic              wbb_stb;
   logic              wbb_we;
   logic [ADDR_W-1:0] wbb_addr;
   logic [STRB_W-1:0] wbb_sel;
   logic [DATA_W-1:0] wbb_wdata;
   logic              wbb_ack;
   logic [DATA_W-1:0] wbb_rdata;

   // shared bus to RAM
   logic              bus_cyc;
   logic              bus_stb;
   logic              bus_we;
   logic [ADDR_W-1:0] bus_addr;
   logic [STRB_W-1:0] bus_sel;
   logic [DATA_W-1:0] bus_wdata;
   logic              bus_ack;
   logic [DATA_W-1:0] bus_rdata;

   iob_wb_bridge bridge_a (
      .clk_i        (clk_i),
      .cke_i        (cke_i),
      .rst_n_i      (rst_n_i),
      .iob_avalid_i (a_iob_avalid_i),
      .iob_addr_i   (a_iob_addr_i),
      .iob_wdata_i  (a_iob_wdata_i),
      .iob_wstrb_i  (a_iob_wstrb_i),
      .iob_ready_o  (a_iob_ready_o),
      .iob_rvalid_o (a_iob_rvalid_o),
      .iob_rdata_o  (a_iob_rdata_o),
      .wb_cyc_o     (wba_cyc),
      .wb_stb_o     (wba_stb),
      .wb_we_o      (wba_we),
      .wb_addr_o    (wba_addr),
      .wb_sel_o     (wba_sel),
      .wb_wdata_o   (wba_wdata),
      .wb_ack_i     (wba_ack),
      .wb_rdata_i   (wba_rdata)
   );

   iob_wb_bridge bridge_b (
      .clk_i        (clk_i),
      .cke_i        (cke_i),
      .rst_n_i      (rst_n_i),
      .iob_avalid_i (b_iob_avalid_i),
      .iob_addr_i   (b_iob_addr_i),
      .iob_wdata_i  (b_iob_wdata_i),
      .iob_wstrb_i  (b_iob_wstrb_i),
      .iob_ready_o  (b_iob_ready_o),
      .iob_rvalid_o (b_iob_rvalid_o),
      .iob_rdata_o  (b_iob_rdata_o),
      .wb_cyc_o     (wbb_cyc),
      .wb_stb_o     (wbb_stb),
      .wb_we_o      (wbb_we),
      .wb_addr_o    (wbb_addr),
      .wb_sel_o     (wbb_sel),
      .wb_wdata_o   (wbb_wdata),
      .wb_ack_i     (wbb_ack),
      .wb_rdata_i   (wbb_rdata)
   );

   wb_arbiter arbiter (
      .clk_i      (clk_i),
      .cke_i      (cke_i),
      .rst_n_i    (rst_n_i),
      .m0_cyc_i   (wba_cyc),
      .m0_stb_i   (wba_stb),
      .m0_we_i    (wba_we),
      .m0_addr_i  (wba_addr),
      .m0_sel_i   (wba_sel),
      .m0_wdata_i (wba_wdata),
      .m0_ack_o   (wba_ack),
      .m0_rdata_o (wba_rdata),
      .m1_cyc_i   (wbb_cyc),
      .m1_stb_i   (wbb_stb),
      .m1_we_i    (wbb_we),
      .m1_addr_i  (wbb_addr),
      .m1_sel_i   (wbb_sel),
      .m1_wdata_i (wbb_wdata),
      .m1_ack_o   (wbb_ack),
      .m1_rdata_o (wbb_rdata),
      .s_cyc_o    (bus_cyc),
      .s_stb_o    (bus_stb),
      .s_we_o     (bus_we),
      .s_addr_o   (bus_addr),
      .s_sel_o    (bus_sel),
      .s_wdata_o  (bus_wdata),
      .s_ack_i    (bus_ack),
      .s_rdata_i  (bus_rdata)
   );

   wb_ram ram (
      .clk_i      (clk_i),
      .cke_i      (cke_i),
      .rst_n_i    (rst_n_i),
      .wb_cyc_i   (bus_cyc),
      .wb_stb_i   (bus_stb),
      .wb_we_i    (bus_we),
      .wb_addr_i  (bus_addr),
      .wb_sel_i   (bus_sel),
      .wb_wdata_i (bus_wdata),
      .wb_ack_o   (bus_ack),
      .wb_rdata_o (bus_rdata)
   );

endmodule

`default_nettype wire

// File: src/wb_ram.sv
`default_nettype none

module wb_ram (
   input  logic                      clk_i,
   input  logic                      cke_i,
   input  logic                      rst_n_i,
   input  logic                      wb_cyc_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_we_i,
   input  logic [wb_pkg::ADDR_W-1:0] wb_addr_i,
   input  logic [wb_pkg::STRB_W-1:0] wb_sel_i,
   input  logic [wb_pkg::DATA_W-1:0] wb_wdata_i,
   output logic                      wb_ack_o,
   output logic [wb_pkg::DATA_W-1:0] wb_rdata_o
);

   import wb_pkg::*;

   logic [DATA_W-1:0] mem[MEM_WORDS];
   logic [DATA_W-1:0] rdata_q;
   logic              ack_q;
   logic [MEM_AW-1:0] idx;
   logic              req;

   assign idx = wb_addr_i[MEM_AW+1:2];  // upper address bits alias
   assign req = wb_cyc_i & wb_stb_i;

   // one wait state, never two acks per cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else if (cke_i) begin
         ack_q <= req & ~ack_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cke_i) begin
         if (req & ack_q & wb_we_i) begin
            for (int i = 0; i < STRB_W; i++) begin
               if (wb_sel_i[i]) begin
                  mem[idx][8*i+:8] <= wb_wdata_i[8*i+:8];
               end
            end
         end
         if (req & ~ack_q & ~wb_we_i) begin
            rdata_q <= mem[idx];  // whole word, lanes picked upstream
         end
      end
   end

   assign wb_ack_o   = ack_q;
   assign wb_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: src/wb_arbiter.sv
`default_nettype none

module wb_arbiter (
   input  logic                      clk_i,
   input  logic                      cke_i,
   input  logic                      rst_n_i,

   // master 0
   input  logic                      m0_cyc_i,
   input  logic                      m0_stb_i,
   input  logic                      m0_we_i,
   input  logic [wb_pkg::ADDR_W-1:0] m0_addr_i,
   input  logic [wb_pkg::STRB_W-1:0] m0_sel_i,
   input  logic [wb_pkg::DATA_W-1:0] m0_wdata_i,
   output logic                      m0_ack_o,
   output logic [wb_pkg::DATA_W-1:0] m0_rdata_o,

   // master 1
   input  logic                      m1_cyc_i,
   input  logic                      m1_stb_i,
   input  logic                      m1_we_i,
   input  logic [wb_pkg::ADDR_W-1:0] m1_addr_i,
   input  logic [wb_pkg::STRB_W-1:0] m1_sel_i,
   input  logic [wb_pkg::DATA_W-1:0] m1_wdata_i,
   output logic                      m1_ack_o,
   output logic [wb_pkg::DATA_W-1:0] m1_rdata_o,

   // shared slave side
   output logic                      s_cyc_o,
   output logic                      s_stb_o,
   output logic                      s_we_o,
   output logic [wb_pkg::ADDR_W-1:0] s_addr_o,
   output logic [wb_pkg::STRB_W-1:0] s_sel_o,
   output logic [wb_pkg::DATA_W-1:0] s_wdata_o,
   input  logic                      s_ack_i,
   input  logic [wb_pkg::DATA_W-1:0] s_rdata_i
);

   import wb_pkg::*;

   logic owner_valid_q;
   logic owner_q;  // 0 is m0, 1 is m1
   logic prio_q;  // master favoured on a tie
   logic gnt;
   logic owner_cyc;

   // free bus grants at once, otherwise the owner keeps it
   always_comb begin
      if (owner_valid_q) begin
         gnt = owner_q;
      end else if (m0_cyc_i & m1_cyc_i) begin
         gnt = prio_q;
      end else begin
         gnt = m1_cyc_i;
      end
   end

   assign owner_cyc = owner_q ? m1_cyc_i : m0_cyc_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         owner_valid_q <= 1'b0;
         owner_q       <= 1'b0;
         prio_q        <= 1'b0;  // a first after reset
      end else if (cke_i) begin
         if (s_ack_i) begin
            owner_valid_q <= 1'b0;
            prio_q        <= ~gnt;  // other side next time
         end else if (owner_valid_q & ~owner_cyc) begin
            owner_valid_q <= 1'b0;  // master gave up the cycle
         end else if (~owner_valid_q & (m0_cyc_i | m1_cyc_i)) begin
            owner_valid_q <= 1'b1;
            owner_q       <= gnt;
         end
      end
   end

   // slave sees the granted master only
   assign s_cyc_o   = gnt ? m1_cyc_i   : m0_cyc_i;
   assign s_stb_o   = gnt ? m1_stb_i   : m0_stb_i;
   assign s_we_o    = gnt ? m1_we_i    : m0_we_i;
   assign s_addr_o  = gnt ? m1_addr_i  : m0_addr_i;
   assign s_sel_o   = gnt ? m1_sel_i   : m0_sel_i;
   assign s_wdata_o = gnt ? m1_wdata_i : m0_wdata_i;

   assign m0_ack_o = s_ack_i & ~gnt;
   assign m1_ack_o = s_ack_i & gnt;

   assign m0_rdata_o = gnt ? {DATA_W{1'b0}} : s_rdata_i;
   assign m1_rdata_o = gnt ? s_rdata_i : {DATA_W{1'b0}};

endmodule

`default_nettype wire

// File: src/iob_wb_bridge.sv
`default_nettype none

module iob_wb_bridge (
   input  logic                        clk_i,
   input  logic                        cke_i,
   input  logic                        rst_n_i,

   // IOb native port
   input  logic                        iob_avalid_i,
   input  logic [  wb_pkg::ADDR_W-1:0] iob_addr_i,
   input  logic [  wb_pkg::DATA_W-1:0] iob_wdata_i,
   input  logic [  wb_pkg::STRB_W-1:0] iob_wstrb_i,
   output logic                        iob_ready_o,
   output logic                        iob_rvalid_o,
   output logic [  wb_pkg::DATA_W-1:0] iob_rdata_o,

   // Wishbone classic master
   output logic                        wb_cyc_o,
   output logic                        wb_stb_o,
   output logic                        wb_we_o,
   output logic [  wb_pkg::ADDR_W-1:0] wb_addr_o,
   output logic [  wb_pkg::STRB_W-1:0] wb_sel_o,
   output logic [  wb_pkg::DATA_W-1:0] wb_wdata_o,
   input  logic                        wb_ack_i,
   input  logic [  wb_pkg::DATA_W-1:0] wb_rdata_i
);

   import wb_pkg::*;

   logic                busy_q;
   logic                rvalid_q;
   logic                we_q;
   logic [ADDR_W-1:0]   addr_q;
   logic [DATA_W-1:0]   wdata_q;
   logic [STRB_W-1:0]   sel_q;
   logic [DATA_W-1:0]   rdata_q;

   logic                req_take;
   logic                req_we;
   logic [2*STRB_W-1:0] rd_mask;
   logic [STRB_W-1:0]   req_sel;
   logic                rd_done;

   // a strobe only counts while ready is high
   assign req_take = iob_avalid_i & ~busy_q;

   // any write strobe makes it a write
   assign req_we = |iob_wstrb_i;

   // read lanes follow the byte offset, upper lanes fall off
   assign rd_mask = {{(2*STRB_W-READ_BYTES){1'b0}}, {READ_BYTES{1'b1}}} << iob_addr_i[1:0];
   assign req_sel = req_we ? iob_wstrb_i : rd_mask[STRB_W-1:0];

   assign rd_done = wb_ack_i & busy_q & ~we_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q   <= 1'b0;
         rvalid_q <= 1'b0;
      end else if (cke_i) begin
         if (req_take) begin
            busy_q <= 1'b1;
         end else if (wb_ack_i) begin
            busy_q <= 1'b0;  // cycle ends after the ack
         end
         rvalid_q <= rd_done;  // single pulse per read
      end
   end

   // request payload, loaded only on capture
   always_ff @(posedge clk_i) begin
      if (cke_i) begin
         if (req_take) begin
            addr_q  <= iob_addr_i;
            wdata_q <= iob_wdata_i;
            we_q    <= req_we;
            sel_q   <= req_sel;
         end
         if (rd_done) begin
            rdata_q <= wb_rdata_i;
         end
      end
   end

   // cyc and stb stay up until acknowledged
   assign wb_cyc_o   = busy_q;
   assign wb_stb_o   = busy_q;
   assign wb_we_o    = we_q;
   assign wb_addr_o  = addr_q;
   assign wb_sel_o   = sel_q;
   assign wb_wdata_o = wdata_q;

   assign iob_ready_o  = ~busy_q;  // back high the cycle after ack
   assign iob_rvalid_o = rvalid_q;
   assign iob_rdata_o  = rdata_q;

endmodule

`default_nettype wire

// File: src/wb_pkg.sv
`default_nettype none

package wb_pkg;

   // bus widths
   localparam int ADDR_W = 32;  // byte address
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;  // one strobe per byte lane

   // bytes picked by a read, before the shift by the low address bits
   localparam int READ_BYTES = 4;

   // on-chip word RAM
   localparam int MEM_WORDS = 256;
   localparam int MEM_AW = 8;  // word index width, log2 of MEM_WORDS

endpackage

`default_nettype wire
